//--- all.f
+incdir+include
design/cpu_priv_pkg.sv
design/fence_seq_pkg.sv
design/sat_counter.sv
design/pipeline_flush_ctrl.sv
design/fence_t_seq.sv
design/flush_ctrl_top.sv
dv/tb_flush_ctrl.sv

//--- Bender.yml
package:
  name: flush_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - design/cpu_priv_pkg.sv
      - design/fence_seq_pkg.sv
      - design/sat_counter.sv
      - design/pipeline_flush_ctrl.sv
      - design/fence_t_seq.sv
      - design/flush_ctrl_top.sv
  - target: simulation
    files:
      - dv/tb_flush_ctrl.sv

//--- dv/tb_flush_ctrl.sv
// Cache, timer and privilege are plain strobe stubs, and only one fence.t is in flight at a time
`timescale 1ns/1ns
`include "flush_ctrl_defines.svh"

module tb_flush_ctrl;

  // Strobe vector {set_pc, if, unissued, id, ex, bp, icache, tlb, vvma, gvma}
  localparam logic [9:0] redirect_mask   = 10'b11111_00000;  // set-PC and four stages
  localparam logic [9:0] trap_mask       = 10'b01111_10000;  // Stages and predictor
  localparam logic [9:0] mispredict_mask = 10'b01100_00000;
  localparam logic [9:0] icache_mask     = 10'b00000_01000;
  localparam logic [9:0] tlb_mask        = 10'b00000_00100;
  localparam logic [9:0] vvma_mask       = 10'b00000_00010;
  localparam logic [9:0] gvma_mask       = 10'b00000_00001;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic v_i;
  logic [`FC_VLEN-1:0] boot_addr_i, pc_commit_i, rst_addr_o;
  cpu_priv_pkg::bp_resolve_t resolved_branch_i;
  logic fence_i, fence_i_i, fence_t_i, sfence_vma_i, hfence_vvma_i, hfence_gvma_i;
  logic flush_csr_i, flush_acc_i, flush_commit_i, ex_valid_i, eret_i, set_debug_pc_i;
  logic halt_csr_i, halt_acc_i, cache_busy_i, time_irq_i;
  logic flush_dcache_ack_i = 1'b0;
  cpu_priv_pkg::priv_lvl_t priv_lvl_i;
  logic [31:0] fence_t_pad_i, fence_t_ceil_o;
  fence_seq_pkg::pad_src_e fence_t_src_sel_i;
  logic set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o;
  logic flush_bp_o, flush_icache_o, flush_dcache_o, flush_tlb_o, flush_tlb_vvma_o;
  logic flush_tlb_gvma_o, halt_o, rst_uarch_no, stall_cache_o, cache_init_no;

  int          cyc = 0;         // Cycle index, stable at the falling edge
  int          n_checks = 0;
  int          n_errors = 0;
  int unsigned rand_state = 95;
  int          ack_delay = 0;   // Cycles between flush request and ack
  int          ack_wait = 0;
  bit          ack_armed = 1'b0;
  int          ack_cyc = -1;    // Cycle of the last ack

  flush_ctrl_top flush_ctrl_top_inst (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period
  always @(posedge clk_i) cyc <= cyc + 1;

  // Dcache model acks each flush request once, ack_delay cycles after it rises
  always @(negedge clk_i) begin
    flush_dcache_ack_i <= 1'b0;
    if (ack_armed) begin
      if (ack_wait == 0) begin
        flush_dcache_ack_i <= 1'b1;
        ack_armed          <= 1'b0;
        ack_cyc            <= cyc;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end else if (flush_dcache_o && !flush_dcache_ack_i) begin
      ack_armed <= 1'b1;
      ack_wait  <= ack_delay;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;  // LCG step
    return rand_state;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  function automatic logic [9:0] observed_strobes();
    return {set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o,
            flush_bp_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o};
  endfunction

  // Event codes 0 mispredict, 1 fence, 2 fence.i, 3 sfence, 4 sfence under V,
  // 5 hfence.vvma, 6 hfence.gvma, 7 CSR, 8 accel, 9 commit, 10 exception,
  // 11 eret, 12 debug, 13 mispredict with exception
  function automatic logic [9:0] expected_strobes(input int ev);
    logic [9:0] exp;
    case (ev)
      0:          exp = mispredict_mask;
      1, 7, 8, 9: exp = redirect_mask;
      2:          exp = redirect_mask | icache_mask;
      3:          exp = redirect_mask | tlb_mask;
      4, 5:       exp = redirect_mask | vvma_mask;  // VS-stage TLB
      6:          exp = redirect_mask | gvma_mask;
      default:    exp = trap_mask;  // Trap swallows the mispredict
    endcase
    return exp;
  endfunction

  task automatic clear_events();
    drive_event(-1);
  endtask

  task automatic drive_event(input int ev);
    resolved_branch_i               = '0;
    resolved_branch_i.valid         = (ev == 0) || (ev == 13);
    resolved_branch_i.is_mispredict = (ev == 0) || (ev == 13);
    resolved_branch_i.pc            = {next_rand(), next_rand()};
    fence_i        = (ev == 1);
    fence_i_i      = (ev == 2);
    fence_t_i      = 1'b0;
    sfence_vma_i   = (ev == 3) || (ev == 4);
    v_i            = (ev == 4);
    hfence_vvma_i  = (ev == 5);
    hfence_gvma_i  = (ev == 6);
    flush_csr_i    = (ev == 7);
    flush_acc_i    = (ev == 8);
    flush_commit_i = (ev == 9);
    ex_valid_i     = (ev == 10) || (ev == 13);
    eret_i         = (ev == 11);
    set_debug_pc_i = (ev == 12);
  endtask

  task automatic wait_halt_low();
    int guard;
    guard = 0;
    while (halt_o && guard < 64) begin
      @(negedge clk_i);
      #1;
      guard++;
    end
    if (halt_o) report_timeout("halt_o to drop");
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic reset_values();
    check("strobes after reset", observed_strobes(), '0);
    check("flush_dcache_o after reset", flush_dcache_o, 1'b0);
    check("halt_o after reset", halt_o, 1'b0);
    check("stall_cache_o after reset", stall_cache_o, 1'b0);
    check("rst_uarch_no after reset", rst_uarch_no, 1'b1);
    check("cache_init_no after reset", cache_init_no, 1'b0);
    check("rst_addr_o after reset", rst_addr_o, boot_addr_i);
    check("fence_t_ceil_o after reset", fence_t_ceil_o, '0);
  endtask

  task automatic event_strobes();
    for (int ev = 0; ev < 14; ev++) begin
      ack_delay = next_rand() % 8;
      @(negedge clk_i);
      drive_event(ev);
      #1;
      check($sformatf("strobes for event %0d", ev), observed_strobes(), expected_strobes(ev));
      @(negedge clk_i);
      clear_events();
      #1;
      check("strobes once event is gone", observed_strobes(), '0);
      wait_halt_low();  // fence and fence.i wait for the ack
    end
  endtask

  // Halt and dcache flush both hold until the ack, then drop together
  task automatic dcache_fence_halt();
    int guard;
    bit acked;
    for (int ev = 1; ev <= 2; ev++) begin
      ack_delay = 1 + next_rand() % 10;
      @(negedge clk_i);
      drive_event(ev);
      @(negedge clk_i);
      clear_events();
      #1;
      guard = 0;
      acked = 1'b0;
      while (!acked && guard < 64) begin
        check("halt_o before ack", halt_o, 1'b1);
        check("flush_dcache_o before ack", flush_dcache_o, 1'b1);
        acked = flush_dcache_ack_i;
        if (!acked) begin
          @(negedge clk_i);
          #1;
          guard++;
        end
      end
      if (!acked) begin
        report_timeout("dcache flush ack");
      end else begin
        @(negedge clk_i);
        #1;
        check("halt_o after ack", halt_o, 1'b0);
        check("flush_dcache_o after ack", flush_dcache_o, 1'b0);
      end
    end
  endtask

  // WFI and accelerator halts pass straight to halt_o
  task automatic halt_inputs();
    @(negedge clk_i);
    halt_csr_i = 1'b1;
    #1;
    check("halt_o on WFI", halt_o, 1'b1);
    @(negedge clk_i);
    halt_csr_i = 1'b0;
    halt_acc_i = 1'b1;
    #1;
    check("halt_o on accelerator halt", halt_o, 1'b1);
    @(negedge clk_i);
    halt_acc_i = 1'b0;
    #1;
    check("halt_o once halts are gone", halt_o, 1'b0);
  endtask

  // Pad event at fence cycle + 2, busy pulses land inside the drain window
  task automatic fence_t_sequence(input fence_seq_pkg::pad_src_e src, input int n_busy,
                                  input int pad);
    logic [`FC_VLEN-1:0] pc;
    int f, k, quiet, last_busy, gap, busy_left, phase, low_len, init_len, guard, exp_low;
    ack_cyc   = -1;
    last_busy = -1;
    busy_left = n_busy;
    gap       = 1 + next_rand() % 8;
    ack_delay = next_rand() % 8;
    @(negedge clk_i);
    pc                = {next_rand(), next_rand()};
    pc_commit_i       = pc;
    fence_t_pad_i     = pad;
    fence_t_src_sel_i = src;
    if (src == fence_seq_pkg::USER_EXIT) priv_lvl_i = cpu_priv_pkg::PRIV_LVL_U;
    else priv_lvl_i = cpu_priv_pkg::PRIV_LVL_M;
    fence_t_i = 1'b1;
    f         = cyc;
    k         = f + 2;
    @(negedge clk_i);
    fence_t_i = 1'b0;
    #1;
    check("rst_addr_o after fence.t", rst_addr_o, pc + `FC_VLEN'(4));
    check("stall_cache_o at start", stall_cache_o, 1'b1);
    phase = 0;
    guard = 0;
    while (phase < 3 && guard < 400) begin
      @(negedge clk_i);
      quiet = (ack_cyc > last_busy) ? ack_cyc : last_busy;  // Last non-idle cycle
      time_irq_i = (src == fence_seq_pkg::TIMER_EDGE) && (cyc == k);
      if (src == fence_seq_pkg::USER_EXIT && cyc == k) priv_lvl_i = cpu_priv_pkg::PRIV_LVL_M;
      cache_busy_i = 1'b0;
      if (busy_left > 0 && ack_cyc >= 0 && cyc - quiet == gap) begin
        cache_busy_i = 1'b1;
        last_busy    = cyc;
        busy_left--;
        gap = 1 + next_rand() % 8;
      end
      #1;
      guard++;
      case (phase)
        0: begin
          check("stall_cache_o in sequence", stall_cache_o, 1'b1);
          check("halt_o in sequence", halt_o, 1'b1);
          check("cache_init_no before microreset", cache_init_no, 1'b0);
          if (cyc == quiet + `FC_DRAIN_CYCLES) begin
            if (cyc - k - 1 < pad) begin
              check("fence_t_ceil_o at drain exit", fence_t_ceil_o, cyc - k - 1);
            end
          end else begin
            check("fence_t_ceil_o outside drain exit", fence_t_ceil_o, '0);
          end
          if (!rst_uarch_no) begin
            exp_low = quiet + `FC_DRAIN_CYCLES + 2;  // Drain, then PAD, then reset
            if (k + 2 + pad > exp_low) exp_low = k + 2 + pad;
            check("first microreset cycle", cyc, exp_low);
            low_len = 1;
            phase   = 1;
          end
        end
        1: begin
          if (!rst_uarch_no) begin
            low_len++;
            check("stall_cache_o in microreset", stall_cache_o, 1'b1);
          end else begin
            check("microreset length", low_len, `FC_RST_CYCLES);
            check("stall_cache_o after sequence", stall_cache_o, 1'b0);
            init_len = cache_init_no ? 1 : 0;
            phase    = 2;
          end
        end
        default: begin
          check("rst_uarch_no after microreset", rst_uarch_no, 1'b1);
          if (cache_init_no) begin
            init_len++;
          end else begin
            check("cache-init hold length", init_len, `FC_INIT_HOLD);
            phase = 3;
          end
        end
      endcase
    end
    if (phase < 3) report_timeout("fence.t sequence to finish");
    check("halt_o after sequence", halt_o, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst_ni            = 1'b0;
    boot_addr_i       = {next_rand(), next_rand()};
    pc_commit_i       = '0;
    halt_csr_i        = 1'b0;
    halt_acc_i        = 1'b0;
    cache_busy_i      = 1'b0;
    time_irq_i        = 1'b0;
    priv_lvl_i        = cpu_priv_pkg::PRIV_LVL_M;
    fence_t_pad_i     = '0;
    fence_t_src_sel_i = fence_seq_pkg::TIMER_EDGE;
    clear_events();
    repeat (5) @(negedge clk_i);  // Five rising edges in reset
    rst_ni = 1'b1;
    #1;
    reset_values();
    event_strobes();
    dcache_fence_halt();
    halt_inputs();
    fence_t_sequence(fence_seq_pkg::TIMER_EDGE, 0, 2 + next_rand() % 8);
    fence_t_sequence(fence_seq_pkg::USER_EXIT, 3, 30 + next_rand() % 20);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- design/flush_ctrl_top.sv
// Plain-port top of the flush and halt controller, where the cache must ack each flush exactly once
`timescale 1ns/1ns
`include "flush_ctrl_defines.svh"

module flush_ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      v_i,
  input  logic [`FC_VLEN-1:0]       boot_addr_i,
  input  logic [`FC_VLEN-1:0]       pc_commit_i,
  input  cpu_priv_pkg::bp_resolve_t resolved_branch_i,
  input  logic                      fence_i,
  input  logic                      fence_i_i,
  input  logic                      fence_t_i,
  input  logic                      sfence_vma_i,
  input  logic                      hfence_vvma_i,
  input  logic                      hfence_gvma_i,
  input  logic                      flush_csr_i,
  input  logic                      flush_acc_i,
  input  logic                      flush_commit_i,
  input  logic                      ex_valid_i,
  input  logic                      eret_i,
  input  logic                      set_debug_pc_i,
  input  logic                      halt_csr_i,
  input  logic                      halt_acc_i,
  input  logic                      flush_dcache_ack_i,
  input  logic                      cache_busy_i,
  input  logic                      time_irq_i,
  input  cpu_priv_pkg::priv_lvl_t   priv_lvl_i,
  input  logic [31:0]               fence_t_pad_i,
  input  fence_seq_pkg::pad_src_e   fence_t_src_sel_i,
  output logic                      set_pc_commit_o,
  output logic                      flush_if_o,
  output logic                      flush_unissued_instr_o,
  output logic                      flush_id_o,
  output logic                      flush_ex_o,
  output logic                      flush_bp_o,
  output logic                      flush_icache_o,
  output logic                      flush_dcache_o,
  output logic                      flush_tlb_o,
  output logic                      flush_tlb_vvma_o,
  output logic                      flush_tlb_gvma_o,
  output logic                      halt_o,
  output logic [`FC_VLEN-1:0]       rst_addr_o,
  output logic                      rst_uarch_no,
  output logic                      stall_cache_o,
  output logic                      cache_init_no,
  output logic [31:0]               fence_t_ceil_o
);

  logic fence_t_start;      // Start strobe for the sequencer
  logic dcache_flush_done;  // Ack qualified by fence-active
  logic seq_active;         // Sequencer out of IDLE, feeds halt

  // Remaining ports share their names with the top
  pipeline_flush_ctrl pipeline_flush_ctrl_inst (
    .*,
    .seq_active_i        (seq_active),
    .fence_t_start_o     (fence_t_start),
    .dcache_flush_done_o (dcache_flush_done)
  );

  fence_t_seq fence_t_seq_inst (
    .*,
    .fence_t_start_i     (fence_t_start),
    .dcache_flush_done_i (dcache_flush_done),
    .seq_active_o        (seq_active)
  );

endmodule

//--- design/fence_t_seq.sv
// One fence.t at a time, and pad events count only while the sequence is running, so earlier ones are lost
`timescale 1ns/1ns
`include "flush_ctrl_defines.svh"

module fence_t_seq (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fence_t_start_i,      // One-cycle start strobe
  input  logic                     dcache_flush_done_i,  // Dcache flush acknowledged
  input  logic                     cache_busy_i,
  input  logic                     time_irq_i,
  input  cpu_priv_pkg::priv_lvl_t  priv_lvl_i,
  input  logic [31:0]              fence_t_pad_i,        // Pad length in cycles
  input  fence_seq_pkg::pad_src_e  fence_t_src_sel_i,
  output logic                     seq_active_o,
  output logic                     rst_uarch_no,         // Microreset, active low
  output logic                     stall_cache_o,        // No new cache requests
  output logic                     cache_init_no,        // Inhibit cache init
  output logic [31:0]              fence_t_ceil_o        // Pad already spent at drain exit
);

  localparam int unsigned DrainW = $clog2(`FC_DRAIN_CYCLES);
  localparam int unsigned RstW   = $clog2(`FC_RST_CYCLES);

  fence_seq_pkg::fence_t_state_e state_d, state_q;
  logic [RstW-1:0]          rst_cnt_d, rst_cnt_q;  // Cycles spent in RST_UARCH
  logic [DrainW-1:0]        drain_cnt;
  logic [31:0]              pad_cnt;
  logic                     pad_trig;    // Selected pad event this cycle
  logic                     time_irq_q;
  cpu_priv_pkg::priv_lvl_t  priv_lvl_q;
  logic                     init_in;     // Feeds the cache-init shifter
  logic [`FC_INIT_HOLD-1:0] init_q;

  // ----------------------------------------------------------
  // Pad trigger and counters
  // ----------------------------------------------------------
  assign pad_trig = (fence_t_src_sel_i == fence_seq_pkg::USER_EXIT)
                  ? (priv_lvl_q == cpu_priv_pkg::PRIV_LVL_U
                     && priv_lvl_i != cpu_priv_pkg::PRIV_LVL_U)
                  : (time_irq_i && !time_irq_q);  // Timer rising edge

  // Counts idle cycles, any busy cycle restarts it
  sat_counter #(
    .WIDTH (DrainW)
  ) drain_cnt_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cache_busy_i || state_q == fence_seq_pkg::FLUSH_DCACHE),
    .en_i    (state_q == fence_seq_pkg::DRAIN_REQS),
    .load_i  (1'b0),
    .down_i  (1'b0),
    .d_i     ('0),
    .q_o     (drain_cnt)
  );

  sat_counter #(
    .WIDTH (32)
  ) pad_cnt_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (state_q == fence_seq_pkg::IDLE),  // Only live inside a sequence
    .en_i    (1'b1),                            // Stops by itself at zero
    .load_i  (pad_trig),
    .down_i  (1'b1),
    .d_i     (fence_t_pad_i),
    .q_o     (pad_cnt)
  );

  // ----------------------------------------------------------
  // Phase FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    rst_cnt_d      = rst_cnt_q;
    rst_uarch_no   = 1'b1;
    fence_t_ceil_o = '0;
    init_in        = 1'b0;
    unique case (state_q)
      fence_seq_pkg::IDLE: begin
        if (fence_t_start_i) state_d = fence_seq_pkg::FLUSH_DCACHE;
      end
      fence_seq_pkg::FLUSH_DCACHE: begin
        if (dcache_flush_done_i) state_d = fence_seq_pkg::DRAIN_REQS;
      end
      fence_seq_pkg::DRAIN_REQS: begin
        // Cache is the only handshaked port, so a quiet cache means no open transfers
        if (drain_cnt == DrainW'(`FC_DRAIN_CYCLES - 1)) begin
          state_d        = fence_seq_pkg::PAD;
          fence_t_ceil_o = (pad_cnt == '0) ? '0 : fence_t_pad_i - pad_cnt;
        end
      end
      fence_seq_pkg::PAD: begin
        if (pad_cnt == '0) state_d = fence_seq_pkg::RST_UARCH;
      end
      fence_seq_pkg::RST_UARCH: begin
        rst_uarch_no = 1'b0;
        init_in      = 1'b1;
        if (rst_cnt_q == RstW'(`FC_RST_CYCLES - 1)) begin
          rst_cnt_d = '0;
          state_d   = fence_seq_pkg::IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + 1'b1;
        end
      end
      default: state_d = fence_seq_pkg::IDLE;  // Recover from a corrupt state
    endcase
  end

  assign seq_active_o  = (state_q != fence_seq_pkg::IDLE);
  assign stall_cache_o = seq_active_o;
  assign cache_init_no = |init_q;  // Stretches past the reset phase

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= fence_seq_pkg::IDLE;
      rst_cnt_q  <= '0;
      time_irq_q <= 1'b0;
      priv_lvl_q <= cpu_priv_pkg::PRIV_LVL_M;
      init_q     <= '0;
    end else begin
      state_q    <= state_d;
      rst_cnt_q  <= rst_cnt_d;
      time_irq_q <= time_irq_i;
      priv_lvl_q <= priv_lvl_i;
      init_q     <= {init_q[`FC_INIT_HOLD-2:0], init_in};
    end
  end

  // State register only ever holds one of the five phases
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {fence_seq_pkg::IDLE, fence_seq_pkg::FLUSH_DCACHE, fence_seq_pkg::DRAIN_REQS,
                    fence_seq_pkg::PAD, fence_seq_pkg::RST_UARCH});

  // Microreset stays inside its phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rst_uarch_no |-> state_q == fence_seq_pkg::RST_UARCH);

  // Each microreset lasts exactly the programmed length
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(rst_uarch_no) |-> !rst_uarch_no [*`FC_RST_CYCLES] ##1 rst_uarch_no);

endmodule

//--- design/pipeline_flush_ctrl.sv
// Write-back dcache acks each flush once, hypervisor fences always built in, one fence in flight
`timescale 1ns/1ns
`include "flush_ctrl_defines.svh"

module pipeline_flush_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      v_i,                  // Virtualization mode
  input  cpu_priv_pkg::bp_resolve_t resolved_branch_i,
  input  logic                      fence_i,
  input  logic                      fence_i_i,
  input  logic                      fence_t_i,
  input  logic                      sfence_vma_i,
  input  logic                      hfence_vvma_i,
  input  logic                      hfence_gvma_i,
  input  logic                      flush_csr_i,          // CSR write with side effects
  input  logic                      flush_acc_i,          // Accelerator flush request
  input  logic                      flush_commit_i,       // Commit stage flush request
  input  logic                      ex_valid_i,           // Exception taken
  input  logic                      eret_i,               // Return from exception
  input  logic                      set_debug_pc_i,       // Debug mode entry
  input  logic                      seq_active_i,         // fence.t sequence running
  input  logic                      flush_dcache_ack_i,
  input  logic [`FC_VLEN-1:0]       boot_addr_i,
  input  logic [`FC_VLEN-1:0]       pc_commit_i,
  input  logic                      halt_csr_i,           // WFI
  input  logic                      halt_acc_i,           // Accelerator dispatcher halt
  output logic                      set_pc_commit_o,      // Redirect PC gen to commit PC
  output logic                      flush_if_o,
  output logic                      flush_unissued_instr_o,
  output logic                      flush_id_o,
  output logic                      flush_ex_o,
  output logic                      flush_bp_o,
  output logic                      flush_icache_o,
  output logic                      flush_dcache_o,       // Registered, held until ack
  output logic                      flush_tlb_o,
  output logic                      flush_tlb_vvma_o,
  output logic                      flush_tlb_gvma_o,
  output logic [`FC_VLEN-1:0]       rst_addr_o,           // Fetch address after microreset
  output logic                      halt_o,
  output logic                      fence_t_start_o,
  output logic                      dcache_flush_done_o
);

  logic                mispredict;      // Front-end only flush
  logic                commit_redirect; // Instructions that restart from commit
  logic                trap;            // Exception class, no set-PC
  logic                dcache_req;      // Events that need a full dcache flush
  logic                flush_dcache_d;
  logic                fence_active_d, fence_active_q;  // Waiting for dcache ack
  logic [`FC_VLEN-1:0] rst_addr_d, rst_addr_q;

  // ----------------------------------------------------------
  // Event decode
  // ----------------------------------------------------------
  assign mispredict = resolved_branch_i.valid && resolved_branch_i.is_mispredict;
  assign commit_redirect = fence_i || fence_i_i || sfence_vma_i || hfence_vvma_i
                        || hfence_gvma_i || flush_csr_i || flush_acc_i || flush_commit_i;
  assign trap       = ex_valid_i || eret_i || set_debug_pc_i;
  assign dcache_req = fence_i || fence_i_i || fence_t_i;  // Write-back cache

  // A trap takes its own PC, so set-PC is cleared
  assign set_pc_commit_o        = commit_redirect && !trap;
  assign flush_if_o             = commit_redirect || trap || mispredict;
  assign flush_unissued_instr_o = commit_redirect || trap || mispredict;
  assign flush_id_o             = commit_redirect || trap;
  assign flush_ex_o             = commit_redirect || trap;
  assign flush_bp_o             = trap;  // Stop speculative fetch across privilege change
  assign flush_icache_o         = fence_i_i || fence_t_i;

  // sfence under V goes to the VS-stage TLB
  assign flush_tlb_o      = sfence_vma_i && !v_i;
  assign flush_tlb_vvma_o = (sfence_vma_i && v_i) || hfence_vvma_i;
  assign flush_tlb_gvma_o = hfence_gvma_i;

  // ----------------------------------------------------------
  // Dcache fence tracking
  // ----------------------------------------------------------
  always_comb begin
    fence_active_d = fence_active_q;
    if (dcache_req) begin
      fence_active_d = 1'b1;
    end else if (fence_active_q && flush_dcache_ack_i) begin
      fence_active_d = 1'b0;  // Cache reports flush complete
    end
  end

  // Keep requesting until the ack lands
  assign flush_dcache_d      = dcache_req || (fence_active_q && !flush_dcache_ack_i);
  assign dcache_flush_done_o = fence_active_q && flush_dcache_ack_i;
  assign fence_t_start_o     = fence_t_i;

  // Resume right after the fence.t
  assign rst_addr_d = fence_t_i ? pc_commit_i + `FC_VLEN'(4) : rst_addr_q;
  assign rst_addr_o = rst_addr_q;

  assign halt_o = halt_csr_i || halt_acc_i || fence_active_q || seq_active_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
      rst_addr_q     <= boot_addr_i;  // Boot from the reset vector
    end else begin
      fence_active_q <= fence_active_d;
      flush_dcache_o <= flush_dcache_d;
      rst_addr_q     <= rst_addr_d;
    end
  end

  // Cache may only ack a flush that this block started
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_dcache_ack_i |-> fence_active_q);

endmodule

//--- design/sat_counter.sv
// Counter stops at zero going down and at all ones going up, and clear beats load, which beats counting
`timescale 1ns/1ns

module sat_counter #(
  parameter int unsigned WIDTH = 4  // Counter width in bits
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,  // Synchronous clear to zero
  input  logic             en_i,     // Count enable
  input  logic             load_i,   // Load d_i
  input  logic             down_i,   // Count direction, high is down
  input  logic [WIDTH-1:0] d_i,      // Load value
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] cnt_d, cnt_q;
  logic             at_limit;  // Next step would wrap

  assign at_limit = down_i ? (cnt_q == '0) : (cnt_q == '1);
  assign q_o      = cnt_q;

  always_comb begin
    cnt_d = cnt_q;
    if (clear_i) begin
      cnt_d = '0;
    end else if (load_i) begin
      cnt_d = d_i;
    end else if (en_i && !at_limit) begin
      cnt_d = down_i ? cnt_q - 1'b1 : cnt_q + 1'b1;  // Hold once the limit is hit
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

//--- design/fence_seq_pkg.sv
// Encodings for the fence.t sequencer and its pad trigger, with state values fixed by declaration order

package fence_seq_pkg;

  // fence.t microreset phases
  typedef enum logic [2:0] {
    IDLE,          // No fence.t in flight
    FLUSH_DCACHE,  // Wait for dcache flush acknowledge
    DRAIN_REQS,    // Wait for the cache to go quiet
    PAD,           // Burn the remaining pad cycles
    RST_UARCH      // Microarchitectural reset asserted
  } fence_t_state_e;

  // Event that loads the pad counter
  typedef enum logic {
    TIMER_EDGE = 1'b0,  // Rising edge of the timer interrupt
    USER_EXIT  = 1'b1   // Leaving U-mode
  } pad_src_e;

endpackage

//--- design/cpu_priv_pkg.sv
// Privilege encoding follows the RISC-V privileged spec and the branch struct holds only what flush logic reads
`include "flush_ctrl_defines.svh"

package cpu_priv_pkg;

  // RISC-V privilege level encoding
  typedef enum logic [1:0] {
    PRIV_LVL_M = 2'b11,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_U = 2'b00
  } priv_lvl_t;

  // Branch as resolved in EX
  typedef struct packed {
    logic                valid;          // Resolution present this cycle
    logic [`FC_VLEN-1:0] pc;             // PC of the branch
    logic [`FC_VLEN-1:0] target;         // Resolved target
    logic                is_mispredict;  // Front-end went the wrong way
  } bp_resolve_t;

endpackage

//--- include/flush_ctrl_defines.svh
// Every length below must be at least 2, and FC_VLEN must match the core's virtual address width
`ifndef FLUSH_CTRL_DEFINES_SVH
`define FLUSH_CTRL_DEFINES_SVH

// Virtual address width of the core
`define FC_VLEN 64

// Idle cache cycles needed before fence.t padding may start
`define FC_DRAIN_CYCLES 16

// Cycles that the microarchitectural reset is held low
`define FC_RST_CYCLES 16

// Cycles of cache-init inhibit after the microreset ends
`define FC_INIT_HOLD 3

`endif
